/* hdl/lc3b_config.svh */
`ifndef LC3B_CONFIG_SVH
`define LC3B_CONFIG_SVH

// data memory size for the EX/MEM slice
// word count and index width must agree
`define LC3B_MEM_WORDS 64
`define LC3B_MEM_ADDR_BITS 6

// value loaded into the pipeline register pc field at reset
`define LC3B_PC_RESET 16'h0000

`endif

/* hdl/lc3b_pkg.sv */
package lc3b_pkg;

	// basic datapath types
	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// condition codes as {n, z, p}
	typedef logic [2:0] lc3b_nzp;

	// instruction classes handled by this slice
	typedef enum logic [2:0]
	{
		OP_ALU = 3'd0,
		OP_LEA = 3'd1,
		OP_LDR = 3'd2,
		OP_LDB = 3'd3,
		OP_LDI = 3'd4,
		OP_STR = 3'd5,
		OP_STB = 3'd6,
		OP_STI = 3'd7
	} lc3b_opcode;

	// ALU operation select
	typedef enum logic [2:0]
	{
		ALU_ADD = 3'd0,
		ALU_AND = 3'd1,
		ALU_NOT = 3'd2,
		ALU_LSHF = 3'd3,
		ALU_RSHFL = 3'd4,
		ALU_RSHFA = 3'd5,
		ALU_PASS = 3'd6
	} lc3b_aluop;

	// decoded, register-read bundle entering execute
	typedef struct packed
	{
		logic valid;
		lc3b_opcode opcode;
		lc3b_aluop aluop;
		lc3b_word pc;
		lc3b_word sr1_val;
		lc3b_word sr2_val;
		// already sign-extended and scaled
		lc3b_word offset;
		logic use_imm;
		lc3b_word imm;
		lc3b_reg dest;
	} id_ex_t;

	// contents of the EX/MEM pipeline register
	typedef struct packed
	{
		logic valid;
		lc3b_opcode opcode;
		lc3b_word alu_out;
		lc3b_word addr_adder_out;
		lc3b_word pc;
		lc3b_reg dest;
		// store source value
		lc3b_word dest_data;
		logic load_regfile;
		logic load_cc;
	} ex_mem_t;

	// registered writeback bundle
	typedef struct packed
	{
		logic valid;
		lc3b_reg dest;
		lc3b_word data;
		logic load_regfile;
		logic load_cc;
		lc3b_nzp nzp;
	} wb_t;

endpackage : lc3b_pkg

/* hdl/lc3b_execute.sv */
`timescale 1ns/1ps

module lc3b_execute
(
	input lc3b_pkg::id_ex_t id_ex_in,
	output lc3b_pkg::ex_mem_t ex_result
);

	import lc3b_pkg::*;

	lc3b_word alu_a;
	lc3b_word alu_b;
	logic [3:0] shamt;
	lc3b_word alu_result;
	lc3b_word addr_base;
	lc3b_word addr_sum;
	logic writes_reg;

	// second operand is either the register or the immediate
	assign alu_a = id_ex_in.sr1_val;
	assign alu_b = id_ex_in.use_imm ? id_ex_in.imm : id_ex_in.sr2_val;

	// shifts only look at the low nibble
	assign shamt = alu_b[3:0];

	always_comb
	begin
		case (id_ex_in.aluop)
			ALU_ADD:
			begin
				alu_result = alu_a + alu_b;
			end
			ALU_AND:
			begin
				alu_result = alu_a & alu_b;
			end
			ALU_NOT:
			begin
				alu_result = ~alu_a;
			end
			ALU_LSHF:
			begin
				alu_result = alu_a << shamt;
			end
			ALU_RSHFL:
			begin
				alu_result = alu_a >> shamt;
			end
			ALU_RSHFA:
			begin
				// arithmetic shift keeps the sign bit
				alu_result = lc3b_word'($signed(alu_a) >>> shamt);
			end
			default:
			begin
				alu_result = alu_b;
			end
		endcase
	end

	// LEA is pc relative and the memory ops are base register relative
	assign addr_base = (id_ex_in.opcode == OP_LEA) ? id_ex_in.pc : id_ex_in.sr1_val;
	assign addr_sum = addr_base + id_ex_in.offset;

	always_comb
	begin
		case (id_ex_in.opcode)
			OP_ALU, OP_LEA, OP_LDR, OP_LDB, OP_LDI:
			begin
				writes_reg = 1'b1;
			end
			default:
			begin
				writes_reg = 1'b0;
			end
		endcase
	end

	always_comb
	begin
		ex_result.valid = id_ex_in.valid;
		ex_result.opcode = id_ex_in.opcode;
		ex_result.addr_adder_out = addr_sum;
		ex_result.pc = id_ex_in.pc;
		ex_result.dest = id_ex_in.dest;
		ex_result.dest_data = id_ex_in.sr2_val;
		ex_result.load_regfile = writes_reg;
		ex_result.load_cc = writes_reg;

		// LEA writes the effective address back
		if (id_ex_in.opcode == OP_LEA)
		begin
			ex_result.alu_out = addr_sum;
		end
		else
		begin
			ex_result.alu_out = alu_result;
		end
	end

endmodule : lc3b_execute

/* hdl/lc3b_ex_mem_reg.sv */
`timescale 1ns/1ps
`include "lc3b_config.svh"

module lc3b_ex_mem_reg
(
	input logic clk,
	input logic arst_n,
	input logic stall,
	input lc3b_pkg::ex_mem_t ex_result,
	output lc3b_pkg::ex_mem_t ex_mem_q
);

	// whole bundle captured as one word and held while the memory stage stalls
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			// bubble out of reset
			ex_mem_q <= '0;
			ex_mem_q.pc <= `LC3B_PC_RESET;
		end
		else if (!stall)
		begin
			ex_mem_q <= ex_result;
		end
	end

endmodule : lc3b_ex_mem_reg

/* hdl/lc3b_mem_stage.sv */
`timescale 1ns/1ps
`include "lc3b_config.svh"

module lc3b_mem_stage
(
	input logic clk,
	input logic arst_n,
	input lc3b_pkg::ex_mem_t ex_mem_q,
	output logic stall,
	output lc3b_pkg::wb_t wb_out
);

	import lc3b_pkg::*;

	lc3b_word mem [`LC3B_MEM_WORDS];

	logic phase;
	lc3b_word ptr_q;
	logic is_indirect;
	lc3b_word acc_addr;
	logic [`LC3B_MEM_ADDR_BITS-1:0] word_idx;
	lc3b_word rd_word;
	lc3b_word rd_byte_sext;
	logic mem_we;
	logic [1:0] byte_en;
	lc3b_word wr_data;
	lc3b_word wb_data;
	wb_t wb_next;

	assign is_indirect = (ex_mem_q.opcode == OP_LDI) || (ex_mem_q.opcode == OP_STI);

	// first cycle of an indirect fetches the pointer
	assign stall = ex_mem_q.valid && is_indirect && !phase;

	// second indirect cycle goes through the saved pointer
	assign acc_addr = phase ? ptr_q : ex_mem_q.addr_adder_out;
	assign word_idx = acc_addr[`LC3B_MEM_ADDR_BITS:1];

	// asynchronous read
	assign rd_word = mem[word_idx];
	assign rd_byte_sext = acc_addr[0] ? {{8{rd_word[15]}}, rd_word[15:8]}
		: {{8{rd_word[7]}}, rd_word[7:0]};

	always_comb
	begin
		mem_we = 1'b0;
		byte_en = 2'b11;
		wr_data = ex_mem_q.dest_data;
		case (ex_mem_q.opcode)
			OP_STR, OP_STI:
			begin
				mem_we = ex_mem_q.valid && !stall;
			end
			OP_STB:
			begin
				mem_we = ex_mem_q.valid;
				byte_en = acc_addr[0] ? 2'b10 : 2'b01;
				// low byte replicated onto both lanes
				wr_data = {ex_mem_q.dest_data[7:0], ex_mem_q.dest_data[7:0]};
			end
			default:
			begin
				mem_we = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < `LC3B_MEM_WORDS; i++)
			begin
				mem[i] <= '0;
			end
		end
		else if (mem_we)
		begin
			if (byte_en[0])
			begin
				mem[word_idx][7:0] <= wr_data[7:0];
			end
			if (byte_en[1])
			begin
				mem[word_idx][15:8] <= wr_data[15:8];
			end
		end
	end

	// flips on each cycle of an indirect item
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			phase <= 1'b0;
		end
		else if (ex_mem_q.valid && is_indirect)
		begin
			phase <= !phase;
		end
	end

	always_ff @(posedge clk)
	begin
		if (stall)
		begin
			ptr_q <= rd_word;
		end
	end

	always_comb
	begin
		case (ex_mem_q.opcode)
			OP_ALU, OP_LEA:
			begin
				wb_data = ex_mem_q.alu_out;
			end
			OP_LDR, OP_LDI:
			begin
				wb_data = rd_word;
			end
			OP_LDB:
			begin
				wb_data = rd_byte_sext;
			end
			default:
			begin
				// stores write nothing back
				wb_data = '0;
			end
		endcase
	end

	always_comb
	begin
		wb_next.valid = ex_mem_q.valid && !stall;
		wb_next.dest = ex_mem_q.dest;
		wb_next.data = wb_data;
		wb_next.load_regfile = ex_mem_q.valid && !stall && ex_mem_q.load_regfile;
		wb_next.load_cc = ex_mem_q.valid && !stall && ex_mem_q.load_cc;
		wb_next.nzp[2] = wb_data[15];
		wb_next.nzp[1] = (wb_data == '0);
		wb_next.nzp[0] = !wb_data[15] && (wb_data != '0);
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			wb_out <= '0;
		end
		else
		begin
			wb_out <= wb_next;
		end
	end

endmodule : lc3b_mem_stage

/* hdl/lc3b_ex_mem_top.sv */
`timescale 1ns/1ps

module lc3b_ex_mem_top
(
	input logic clk,
	input logic arst_n,
	input lc3b_pkg::id_ex_t id_ex_in,
	output logic stall,
	output lc3b_pkg::wb_t wb_out
);

	import lc3b_pkg::*;

	// combinational execute result
	ex_mem_t ex_result;

	// registered EX/MEM contents
	ex_mem_t ex_mem_q;

	lc3b_execute i_lc3b_execute
	(
		.id_ex_in(id_ex_in),
		.ex_result(ex_result)
	);

	// held while the memory stage works through an indirect
	lc3b_ex_mem_reg i_lc3b_ex_mem_reg
	(
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.ex_result(ex_result),
		.ex_mem_q(ex_mem_q)
	);

	lc3b_mem_stage i_lc3b_mem_stage
	(
		.clk(clk),
		.arst_n(arst_n),
		.ex_mem_q(ex_mem_q),
		.stall(stall),
		.wb_out(wb_out)
	);

endmodule : lc3b_ex_mem_top

/* verif/tb_lc3b_ex_mem_top.sv */
`timescale 1ns/1ps
`include "lc3b_config.svh"

module tb_lc3b_ex_mem_top;

	import lc3b_pkg::*;

	// items sent by the directed and random tests
	localparam int item_count = 28 + 8 + 5 + 40;
	localparam int watchdog_cycles = item_count * 4 + 20;

	// one outstanding writeback and the cycle it is due in
	typedef struct packed
	{
		wb_t wb;
		logic [31:0] due_cycle;
	} expect_t;

	logic clk;
	logic arst_n;
	id_ex_t id_ex_in;
	logic stall;
	wb_t wb_out;

	lc3b_word model_mem [`LC3B_MEM_WORDS];
	expect_t exp_q [$];
	expect_t cur;
	logic [15:0] lfsr_state = 16'd50568;
	int cycle_count = 0;
	int accepted_count = 0;
	int indirect_count = 0;
	int stall_pulses = 0;
	int stall_run = 0;
	int check_count = 0;
	int error_count = 0;
	int fail_count = 0;

	lc3b_ex_mem_top i_lc3b_ex_mem_top
	(
		.clk(clk),
		.arst_n(arst_n),
		.id_ex_in(id_ex_in),
		.stall(stall),
		.wb_out(wb_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle_count <= cycle_count + 1;
	end

	// galois lfsr stepped once per bit taken
	function automatic lc3b_word random_bits(input int n);
		lc3b_word r;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			r = {r[14:0], lfsr_state[0]};
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 16'hB400 : lfsr_state >> 1;
		end
		return r;
	endfunction

	function automatic id_ex_t make_item(input lc3b_opcode op, input lc3b_aluop aluop,
		input lc3b_word sr1, input lc3b_word sr2, input lc3b_word offset);
		id_ex_t item;
		item.valid = 1'b1;
		item.opcode = op;
		item.aluop = aluop;
		item.pc = random_bits(16);
		item.sr1_val = sr1;
		item.sr2_val = sr2;
		item.offset = offset;
		item.use_imm = 1'(random_bits(1));
		item.imm = random_bits(16);
		item.dest = lc3b_reg'(random_bits(3));
		return item;
	endfunction

	function automatic int word_index(input lc3b_word addr);
		return int'(addr[`LC3B_MEM_ADDR_BITS:1]);
	endfunction

	function automatic lc3b_word shift_right_arith(input lc3b_word a, input logic [3:0] n);
		lc3b_word r;
		r = a;
		for (int i = 0; i < n; i++)
		begin
			r = {r[15], r[15:1]};
		end
		return r;
	endfunction

	// reference model applied in acceptance order
	function automatic void model_accept(input id_ex_t item, input int accept_cycle);
		lc3b_word b;
		lc3b_word addr;
		lc3b_word ptr;
		lc3b_word data;
		lc3b_word word;
		expect_t e;
		b = item.use_imm ? item.imm : item.sr2_val;
		addr = item.sr1_val + item.offset;
		data = '0;
		case (item.opcode)
			OP_ALU:
			begin
				case (item.aluop)
					ALU_ADD: data = item.sr1_val + b;
					ALU_AND: data = item.sr1_val & b;
					ALU_NOT: data = ~item.sr1_val;
					ALU_LSHF: data = item.sr1_val << b[3:0];
					ALU_RSHFL: data = item.sr1_val >> b[3:0];
					ALU_RSHFA: data = shift_right_arith(item.sr1_val, b[3:0]);
					default: data = b;
				endcase
			end
			OP_LEA: data = item.pc + item.offset;
			OP_LDR: data = model_mem[word_index(addr)];
			OP_LDB:
			begin
				word = model_mem[word_index(addr)];
				data = addr[0] ? {{8{word[15]}}, word[15:8]} : {{8{word[7]}}, word[7:0]};
			end
			OP_LDI:
			begin
				ptr = model_mem[word_index(addr)];
				data = model_mem[word_index(ptr)];
			end
			OP_STR: model_mem[word_index(addr)] = item.sr2_val;
			OP_STB:
			begin
				if (addr[0])
				begin
					model_mem[word_index(addr)][15:8] = item.sr2_val[7:0];
				end
				else
				begin
					model_mem[word_index(addr)][7:0] = item.sr2_val[7:0];
				end
			end
			default:
			begin
				ptr = model_mem[word_index(addr)];
				model_mem[word_index(ptr)] = item.sr2_val;
			end
		endcase
		e.wb.valid = 1'b1;
		e.wb.dest = item.dest;
		e.wb.data = data;
		e.wb.load_regfile = !(item.opcode inside {OP_STR, OP_STB, OP_STI});
		e.wb.load_cc = e.wb.load_regfile;
		e.wb.nzp = {data[15], data == 16'h0000, !data[15] && (data != 16'h0000)};
		// indirect items spend an extra cycle in the memory stage
		e.due_cycle = accept_cycle + ((item.opcode inside {OP_LDI, OP_STI}) ? 2 : 1);
		if (item.opcode inside {OP_LDI, OP_STI})
		begin
			indirect_count++;
		end
		accepted_count++;
		exp_q.push_back(e);
	endfunction

	task automatic check_value(input string name, input lc3b_word expected,
		input lc3b_word actual);
		check_count++;
		assert (actual === expected) else
		begin
			error_count++;
			$display("error at %0t ns: %s expected %h got %h", $time, name, expected, actual);
		end
	endtask

	// held until the pipeline takes it
	task automatic send_item(input id_ex_t item);
		int accept_cycle;
		id_ex_in <= item;
		@(negedge clk);
		while (stall)
		begin
			@(negedge clk);
		end
		accept_cycle = cycle_count + 1;
		@(posedge clk);
		model_accept(item, accept_cycle);
	endtask

	task automatic send_idle();
		id_ex_in <= '0;
		@(posedge clk);
	endtask

	task automatic run_alu_tests();
		lc3b_opcode op;
		for (int r = 0; r < 4; r++)
		begin
			for (int k = 0; k < 7; k++)
			begin
				op = (k == 6) ? OP_LEA : OP_ALU;
				send_item(make_item(op, lc3b_aluop'(k % 6), random_bits(16), random_bits(16),
					random_bits(16)));
			end
		end
	endtask

	task automatic run_load_store_tests();
		send_item(make_item(OP_STR, ALU_PASS, 16'h0010, random_bits(16), 16'h0000));
		send_item(make_item(OP_LDR, ALU_PASS, 16'h0010, 16'h0000, 16'h0000));
		// odd address hits the high lane only
		send_item(make_item(OP_STB, ALU_PASS, 16'h0010, random_bits(16), 16'h0001));
		send_item(make_item(OP_LDR, ALU_PASS, 16'h0008, 16'h0000, 16'h0008));
		send_item(make_item(OP_LDB, ALU_PASS, 16'h0010, 16'h0000, 16'h0001));
		send_item(make_item(OP_LDB, ALU_PASS, 16'h0010, 16'h0000, 16'h0000));
		send_item(make_item(OP_STB, ALU_PASS, 16'h0012, random_bits(16), 16'h0000));
		send_item(make_item(OP_LDR, ALU_PASS, 16'h0012, 16'h0000, 16'h0000));
	endtask

	task automatic run_indirect_tests();
		// pointer at 0x20 refers to 0x30
		send_item(make_item(OP_STR, ALU_PASS, 16'h0020, 16'h0030, 16'h0000));
		send_item(make_item(OP_STR, ALU_PASS, 16'h0030, random_bits(16), 16'h0000));
		send_idle();
		send_item(make_item(OP_LDI, ALU_PASS, 16'h0020, 16'h0000, 16'h0000));
		send_idle();
		send_idle();
		send_item(make_item(OP_STI, ALU_PASS, 16'h0010, random_bits(16), 16'h0010));
		send_item(make_item(OP_LDR, ALU_PASS, 16'h0030, 16'h0000, 16'h0000));
	endtask

	task automatic run_mixed_stream();
		for (int n = 0; n < 40; n++)
		begin
			send_item(make_item(lc3b_opcode'(random_bits(3)), lc3b_aluop'(random_bits(3) % 7),
				random_bits(16), random_bits(16), random_bits(16)));
		end
	endtask

	always @(negedge clk)
	begin
		// nothing may come out before the first item goes in
		if (accepted_count == 0)
		begin
			check_value("stall", 16'h0000, stall);
			check_value("wb_out.valid", 16'h0000, wb_out.valid);
		end
		if (arst_n && wb_out.valid)
		begin
			assert (exp_q.size() != 0) else
			begin
				fail_count++;
				$display("writeback at %0t ns with no item outstanding", $time);
			end
			if (exp_q.size() != 0)
			begin
				cur = exp_q.pop_front();
				check_value("wb_out.dest", cur.wb.dest, wb_out.dest);
				check_value("wb_out.data", cur.wb.data, wb_out.data);
				check_value("wb_out.load_regfile", cur.wb.load_regfile, wb_out.load_regfile);
				check_value("wb_out.load_cc", cur.wb.load_cc, wb_out.load_cc);
				check_value("wb_out.nzp", cur.wb.nzp, wb_out.nzp);
				assert (cycle_count == cur.due_cycle) else
				begin
					fail_count++;
					$display("writeback at %0t ns came in cycle %0d instead of cycle %0d",
						$time, cycle_count, cur.due_cycle);
				end
			end
		end
		if (stall)
		begin
			if (stall_run == 0)
			begin
				stall_pulses++;
			end
			stall_run++;
		end
		else if (stall_run != 0)
		begin
			assert (stall_run == 1) else
			begin
				fail_count++;
				$display("stall stayed high for %0d cycles before %0t ns", stall_run, $time);
			end
			stall_run = 0;
		end
	end

	initial
	begin
		repeat (watchdog_cycles + 3) @(posedge clk);
		$display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
		$display("sim failed");
		$finish;
	end

	initial
	begin
		id_ex_in = '0;
		arst_n = 1'b0;
		foreach (model_mem[i])
		begin
			model_mem[i] = '0;
		end
		repeat (3) @(posedge clk);
		arst_n <= 1'b1;
		repeat (3) send_idle();
		run_alu_tests();
		run_load_store_tests();
		run_indirect_tests();
		run_mixed_stream();
		// let the last writebacks drain
		id_ex_in <= '0;
		while (exp_q.size() != 0)
		begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		assert (stall_pulses == indirect_count) else
		begin
			fail_count++;
			$display("saw %0d stall pulses for %0d indirect items", stall_pulses, indirect_count);
		end
		$display("items %0d, checks %0d, value errors %0d, other errors %0d",
			accepted_count, check_count, error_count, fail_count);
		if (error_count == 0 && fail_count == 0)
		begin
			$display("sim passed");
		end
		else
		begin
			$display("sim failed");
		end
		$finish;
	end

endmodule : tb_lc3b_ex_mem_top

/* lc3b_ex_mem_top.f */
+incdir+hdl
hdl/lc3b_pkg.sv
hdl/lc3b_execute.sv
hdl/lc3b_ex_mem_reg.sv
hdl/lc3b_mem_stage.sv
hdl/lc3b_ex_mem_top.sv
verif/tb_lc3b_ex_mem_top.sv
